/* verilog/isa_pkg.sv */
// architectural widths and register/data types shared by the ROB and its neighbours
`default_nettype none

package isa_pkg;

    // datapath
    localparam int xlen    = 32;
    localparam int reg_len = 5;

    typedef logic [reg_len-1:0] reg_idx_t;
    typedef logic [xlen-1:0]    word_t;

    // r0 reads as zero, writes to it are dropped
    localparam reg_idx_t zero_reg = '0;

endpackage

`default_nettype wire

/* verilog/rob_pkg.sv */
// reorder buffer geometry, tag and entry types, referenced by scoped name in the ROB blocks
`default_nettype none

package rob_pkg;

    localparam int rob_len       = 8;
    localparam int rob_tag_width = $clog2(rob_len); // 3 for 8 entries

    // entry index, wraps modulo rob_len
    typedef logic [rob_tag_width-1:0] rob_tag_t;

    // 0 .. rob_len, so one bit wider than a tag
    typedef logic [rob_tag_width:0] rob_count_t;

    // one ROB slot
    typedef struct packed {
        logic             done;       // result present
        logic             mispredict; // squash when this reaches head
        isa_pkg::reg_idx_t dest;
        isa_pkg::word_t    value;
    } rob_entry_t;

endpackage

`default_nettype wire

/* verilog/rob_alloc_if.sv */
// allocation and squash bundle between the dispatch side, the entry array and the retire side
`timescale 1ns/1ps
`default_nettype none

interface rob_alloc_if;

    logic              alloc;       // one entry written this edge
    rob_pkg::rob_tag_t alloc_tag;   // slot being filled
    isa_pkg::reg_idx_t alloc_dest;
    logic              squash;      // from retire, flushes everything

    modport dispatch_side (
        output alloc,
        output alloc_tag,
        output alloc_dest,
        input  squash
    );

    modport array_side (
        input  alloc,
        input  alloc_tag,
        input  alloc_dest,
        input  squash
    );

    modport retire_side (
        output squash
    );

endinterface

`default_nettype wire

/* verilog/rob_head_if.sv */
// head pointer and head entry exchange between the entry array and the retire logic
`timescale 1ns/1ps
`default_nettype none

interface rob_head_if;

    rob_pkg::rob_entry_t head_entry; // contents of the oldest slot
    rob_pkg::rob_tag_t   head_tag;
    logic                retire;     // head slot leaves this edge

    modport array_side (
        output head_entry,
        input  head_tag,
        input  retire
    );

    modport retire_side (
        input  head_entry,
        output head_tag,
        output retire
    );

endinterface

`default_nettype wire

/* verilog/rob_dispatch.sv */
// ROB input side: tail pointer, occupancy count and full flag; issues one allocation per dispatch
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall,
    input  wire logic              dispatch_valid,
    input  wire isa_pkg::reg_idx_t dispatch_dest,
    input  wire logic              retire,
    output rob_pkg::rob_tag_t      dispatch_tag,
    output logic                   rob_full,
    rob_alloc_if.dispatch_side     alloc
);

    rob_pkg::rob_tag_t   tail_q;
    rob_pkg::rob_count_t count_q;
    rob_pkg::rob_count_t count_d;

    assign rob_full     = (count_q == rob_pkg::rob_count_t'(rob_pkg::rob_len));
    assign dispatch_tag = tail_q; // tag handed back to the RS / map table

    // a dispatch only lands when there is room and nothing is frozen or flushed
    assign alloc.alloc      = dispatch_valid && !rob_full && !stall && !alloc.squash;
    assign alloc.alloc_tag  = tail_q;
    assign alloc.alloc_dest = dispatch_dest;

    always_comb begin
        count_d = count_q;
        case ({alloc.alloc, retire})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q; // both or neither
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tail_q  <= '0;
            count_q <= '0;
        end else if (alloc.squash) begin
            // flush, back to an empty buffer
            tail_q  <= '0;
            count_q <= '0;
        end else if (!stall) begin
            if (alloc.alloc) begin
                tail_q <= tail_q + 1'b1; // wraps at rob_len
            end
            count_q <= count_d;
        end
    end

    // a full buffer must not move its tail, whatever dispatch does
    full_holds_tail: assert property (
        @(posedge clock) disable iff (reset)
        (rob_full && !alloc.squash) |=> (tail_q == $past(tail_q))
    );

    // occupancy bookkeeping must agree with retire from the other block
    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        count_q <= rob_pkg::rob_count_t'(rob_pkg::rob_len)
    );

endmodule

`default_nettype wire

/* verilog/rob_entry_array.sv */
// ROB entry storage: allocation, CDB completion, mispredict marking and RS operand read ports
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall,
    input  wire logic              cdb_valid,
    input  wire rob_pkg::rob_tag_t cdb_tag,
    input  wire isa_pkg::word_t    cdb_value,
    input  wire logic              cdb_taken,
    input  wire rob_pkg::rob_tag_t rs1_tag,
    input  wire rob_pkg::rob_tag_t rs2_tag,
    output isa_pkg::word_t         rs1_value,
    output logic                   rs1_ready,
    output isa_pkg::word_t         rs2_value,
    output logic                   rs2_ready,
    rob_alloc_if.array_side        alloc,
    rob_head_if.array_side         head
);

    rob_pkg::rob_entry_t entries [rob_pkg::rob_len];
    rob_pkg::rob_tag_t   cdb_next_tag;

    // not-taken prediction, so the slot after a taken branch is wrong path
    assign cdb_next_tag = cdb_tag + 1'b1;

    // forwarding to the reservation stations
    assign rs1_value = entries[rs1_tag].value;
    assign rs1_ready = entries[rs1_tag].done;
    assign rs2_value = entries[rs2_tag].value;
    assign rs2_ready = entries[rs2_tag].done;

    assign head.head_entry = entries[head.head_tag];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rob_pkg::rob_len; i++) begin
                entries[i].done       <= 1'b0;
                entries[i].mispredict <= 1'b0;
            end
        end else if (!stall) begin
            if (head.retire) begin
                entries[head.head_tag].done       <= 1'b0; // slot free again
                entries[head.head_tag].mispredict <= 1'b0;
            end

            // dispatch already gated alloc with full, stall and squash
            if (alloc.alloc) begin
                entries[alloc.alloc_tag].dest <= alloc.alloc_dest;
                entries[alloc.alloc_tag].done <= 1'b0;
            end

            if (cdb_valid) begin
                entries[cdb_tag].done  <= 1'b1;
                entries[cdb_tag].value <= cdb_value;
                if (cdb_taken) begin
                    entries[cdb_next_tag].mispredict <= 1'b1;
                end
            end

            // flush wins over everything above
            if (alloc.squash) begin
                for (int i = 0; i < rob_pkg::rob_len; i++) begin
                    entries[i].done       <= 1'b0;
                    entries[i].mispredict <= 1'b0;
                end
            end
        end
    end

    // each tag completes once between allocation and retire
    no_double_complete: assert property (
        @(posedge clock) disable iff (reset)
        (cdb_valid && !stall) |-> !entries[cdb_tag].done
    );

endmodule

`default_nettype wire

/* verilog/rob_retire.sv */
// ROB output side: head pointer, squash/retire decision and the register file commit port
`timescale 1ns/1ps
`default_nettype none

module rob_retire (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         stall,
    output logic              commit_valid,
    output isa_pkg::reg_idx_t commit_dest,
    output isa_pkg::word_t    commit_value,
    output logic              squash,
    output rob_pkg::rob_tag_t head_tag,
    rob_head_if.retire_side   head,
    rob_alloc_if.retire_side  alloc
);

    rob_pkg::rob_tag_t head_q;

    // wrong-path entry at head, squash takes priority over retire
    assign squash       = head.head_entry.mispredict && !stall;
    assign alloc.squash = squash;

    assign head.retire   = head.head_entry.done && !squash && !stall;
    assign head.head_tag = head_q;
    assign head_tag      = head_q;

    // writes to r0 still retire but never reach the register file
    assign commit_valid = head.retire && (head.head_entry.dest != isa_pkg::zero_reg);
    assign commit_dest  = head.head_entry.dest;
    assign commit_value = head.head_entry.value;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
        end else if (squash) begin
            head_q <= '0; // tail and count clear on the same edge
        end else if (head.retire) begin
            head_q <= head_q + 1'b1;
        end
    end

    // a squash cycle commits nothing
    squash_no_commit: assert property (
        @(posedge clock) disable iff (reset)
        squash |-> !commit_valid
    );

endmodule

`default_nettype wire

/* verilog/rob_top.sv */
// reorder buffer top level, plain ports; connects dispatch, entry array and retire blocks
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall,
    input  wire logic              dispatch_valid,
    input  wire isa_pkg::reg_idx_t dispatch_dest,
    input  wire logic              cdb_valid,
    input  wire rob_pkg::rob_tag_t cdb_tag,
    input  wire isa_pkg::word_t    cdb_value,
    input  wire logic              cdb_taken,
    input  wire rob_pkg::rob_tag_t rs1_tag,
    input  wire rob_pkg::rob_tag_t rs2_tag,
    output rob_pkg::rob_tag_t      dispatch_tag,
    output logic                   rob_full,
    output isa_pkg::word_t         rs1_value,
    output logic                   rs1_ready,
    output isa_pkg::word_t         rs2_value,
    output logic                   rs2_ready,
    output logic                   commit_valid,
    output isa_pkg::reg_idx_t      commit_dest,
    output isa_pkg::word_t         commit_value,
    output logic                   squash,
    output rob_pkg::rob_tag_t      head_tag
);

    rob_alloc_if alloc_bus ();
    rob_head_if  head_bus ();

    rob_dispatch dispatch0 (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .retire         (head_bus.retire), // frees a slot in the count
        .dispatch_tag   (dispatch_tag),
        .rob_full       (rob_full),
        .alloc          (alloc_bus.dispatch_side)
    );

    rob_entry_array array0 (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .cdb_taken (cdb_taken),
        .rs1_tag   (rs1_tag),
        .rs2_tag   (rs2_tag),
        .rs1_value (rs1_value),
        .rs1_ready (rs1_ready),
        .rs2_value (rs2_value),
        .rs2_ready (rs2_ready),
        .alloc     (alloc_bus.array_side),
        .head      (head_bus.array_side)
    );

    rob_retire retire0 (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_value (commit_value),
        .squash       (squash),
        .head_tag     (head_tag),
        .head         (head_bus.retire_side),
        .alloc        (alloc_bus.retire_side)
    );

endmodule

`default_nettype wire

/* tb/rob_tb.sv */
// ROB testbench: replays tb/rob_cases.txt one line per clock cycle and checks the DUT outputs
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    localparam int reset_cycles = 5;
    localparam int num_fields   = 16; // 8 inputs, then 8 expected outputs

    logic              clock;
    logic              reset;
    logic              stall;
    logic              dispatch_valid;
    isa_pkg::reg_idx_t dispatch_dest;
    logic              cdb_valid;
    rob_pkg::rob_tag_t cdb_tag;
    isa_pkg::word_t    cdb_value;
    logic              cdb_taken;
    rob_pkg::rob_tag_t rs1_tag;
    rob_pkg::rob_tag_t rs2_tag;

    rob_pkg::rob_tag_t dispatch_tag;
    logic              rob_full;
    isa_pkg::word_t    rs1_value;
    logic              rs1_ready;
    isa_pkg::word_t    rs2_value;
    logic              rs2_ready;
    logic              commit_valid;
    isa_pkg::reg_idx_t commit_dest;
    isa_pkg::word_t    commit_value;
    logic              squash;
    rob_pkg::rob_tag_t head_tag;

    string case_lines [$];      // one entry per clock cycle
    string tok [num_fields];    // fields of the current line
    int    cycle_count;
    int    timeout_limit;

    rob_pkg::rob_tag_t              expected_head;
    logic [rob_pkg::rob_len-1:0]    done_model; // slots holding a result

    rob_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_taken      (cdb_taken),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .dispatch_tag   (dispatch_tag),
        .rob_full       (rob_full),
        .rs1_value      (rs1_value),
        .rs1_ready      (rs1_ready),
        .rs2_value      (rs2_value),
        .rs2_ready      (rs2_ready),
        .commit_valid   (commit_valid),
        .commit_dest    (commit_dest),
        .commit_value   (commit_value),
        .squash         (squash),
        .head_tag       (head_tag)
    );

    always #2 clock = ~clock; // 4 ns period

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // comment lines and blank lines are dropped
    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tb/rob_cases.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the case file tb/rob_cases.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 2 && line.getc(0) != "/") begin
                case_lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic split_line(input int idx);
        int n;
        n = $sscanf(case_lines[idx], "%s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s",
                    tok[0], tok[1], tok[2], tok[3], tok[4], tok[5], tok[6], tok[7],
                    tok[8], tok[9], tok[10], tok[11], tok[12], tok[13], tok[14], tok[15]);
        assert (n == num_fields) else begin
            $display("case line %0d has %0d fields instead of %0d", idx, n, num_fields);
            stop_with_failure();
        end
    endtask

    // hex field, a dash reads as zero
    function automatic logic [31:0] field_value(input string t);
        logic [31:0] v;
        v = '0;
        if (t != "-") begin
            void'($sscanf(t, "%h", v));
        end
        return v;
    endfunction

    task automatic drive_inputs();
        stall          = field_value(tok[0]) != 0;
        dispatch_valid = field_value(tok[1]) != 0;
        dispatch_dest  = isa_pkg::reg_idx_t'(field_value(tok[2]));
        cdb_valid      = field_value(tok[3]) != 0;
        cdb_tag        = rob_pkg::rob_tag_t'(field_value(tok[4]));
        cdb_value      = isa_pkg::word_t'(field_value(tok[5]));
        cdb_taken      = field_value(tok[6]) != 0;
        rs1_tag        = rob_pkg::rob_tag_t'(field_value(tok[7]));
        rs2_tag        = rob_pkg::rob_tag_t'(field_value(tok[7])); // both ports on one slot
    endtask

    task automatic check_field(input string name, input string t, input logic [31:0] actual,
                               input int idx);
        logic [31:0] expected;
        expected = field_value(t);
        if (t != "-") begin
            assert (actual === expected) else begin
                $display("Mismatch %s in case %0d: expected 0x%h, got 0x%h",
                         name, idx, expected, actual);
                stop_with_failure();
            end
        end
    endtask

    task automatic check_outputs(input int idx);
        check_field("commit_valid", tok[8], 32'(commit_valid), idx);
        check_field("commit_dest", tok[9], 32'(commit_dest), idx);
        check_field("commit_value", tok[10], 32'(commit_value), idx);
        check_field("squash", tok[11], 32'(squash), idx);
        check_field("rob_full", tok[12], 32'(rob_full), idx);
        check_field("dispatch_tag", tok[13], 32'(dispatch_tag), idx);
        check_field("rs1_value", tok[14], 32'(rs1_value), idx);
        check_field("rs1_ready", tok[15], 32'(rs1_ready), idx);
        check_field("rs2_value", tok[14], 32'(rs2_value), idx);
        check_field("rs2_ready", tok[15], 32'(rs2_ready), idx);
        assert (head_tag === expected_head) else begin
            $display("Mismatch head_tag in case %0d: expected 0x%h, got 0x%h",
                     idx, expected_head, head_tag);
            stop_with_failure();
        end
    endtask

    // head steps once per retire of a completed slot, squash sends it back to zero
    task automatic track_head();
        if (!stall) begin
            if (field_value(tok[11]) != 0) begin
                expected_head = '0;
                done_model    = '0;
            end else begin
                if (done_model[expected_head]) begin
                    done_model[expected_head] = 1'b0;
                    expected_head = expected_head + 1'b1;
                end
                if (cdb_valid) begin
                    done_model[cdb_tag] = 1'b1;
                end
            end
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        stall          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_dest  = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        cdb_taken      = 1'b0;
        rs1_tag        = '0;
        rs2_tag        = '0;
        cycle_count    = 0;
        expected_head  = '0;
        done_model     = '0;
        load_cases();
        timeout_limit = case_lines.size() + reset_cycles + 20;

        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < case_lines.size(); i++) begin
            @(posedge clock);
            #1;             // inputs change after the edge
            split_line(i);
            drive_inputs();
            #2;             // outputs settled, next edge 1 ns away
            check_outputs(i);
            track_head();
        end

        @(posedge clock);
        $display("NO ERRORS");
        $finish;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the case replay did not finish within %0d cycles",
                     timeout_limit);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

/* tb/rob_cases.txt */
// stall dispatch_valid dispatch_dest cdb_valid cdb_tag cdb_value cdb_taken rs1_tag | expected:
// commit_valid commit_dest commit_value squash rob_full dispatch_tag rs1_value rs1_ready (hex, - skips)
0 0 0 0 0 0   0 0  0 - -   0 0 0 -   0
0 1 1 0 0 0   0 0  0 - -   0 0 0 -   0
0 1 2 0 0 0   0 0  0 - -   0 0 1 -   0
0 1 3 0 0 0   0 0  0 - -   0 0 2 -   0
0 1 0 0 0 0   0 0  0 - -   0 0 3 -   0
0 1 5 0 0 0   0 0  0 - -   0 0 4 -   0
0 1 6 0 0 0   0 0  0 - -   0 0 5 -   0
0 1 7 0 0 0   0 0  0 - -   0 0 6 -   0
0 1 8 0 0 0   0 0  0 - -   0 0 7 -   0
0 1 9 0 0 0   0 0  0 - -   0 1 0 -   0
0 0 0 0 0 0   0 2  0 - -   0 1 0 -   0
0 0 0 1 2 22  0 2  0 - -   0 1 0 -   0
0 0 0 1 0 100 0 2  0 - -   0 1 0 22  1
0 0 0 1 1 111 0 0  1 1 100 0 1 0 100 1
0 0 0 0 0 0   0 1  1 2 111 0 0 0 111 1
0 0 0 0 0 0   0 2  1 3 22  0 0 0 22  1
0 0 0 1 3 33  0 2  0 0 -   0 0 0 22  0
0 0 0 0 0 0   0 3  0 0 33  0 0 0 33  1
0 0 0 1 4 44  1 4  0 5 -   0 0 0 -   0
0 0 0 0 0 0   0 4  1 5 44  0 0 0 44  1
0 0 0 0 0 0   0 5  0 6 -   1 0 0 -   0
0 0 0 0 0 0   0 4  0 - -   0 0 0 44  0
0 1 9 0 0 0   0 0  0 - -   0 0 0 -   0
0 1 a 1 0 90  0 0  0 - -   0 0 1 -   0
1 1 b 1 1 91  0 0  0 - -   0 0 2 90  1
1 1 b 1 1 91  0 0  0 - -   0 0 2 90  1
0 0 0 0 0 0   0 1  1 9 90  0 0 2 -   0
0 0 0 1 1 91  0 1  0 a -   0 0 2 -   0
0 0 0 0 0 0   0 1  1 a 91  0 0 2 91  1
0 0 0 0 0 0   0 0  0 - -   0 0 2 -   0

/* src.f */
verilog/isa_pkg.sv
verilog/rob_pkg.sv
verilog/rob_alloc_if.sv
verilog/rob_head_if.sv
verilog/rob_dispatch.sv
verilog/rob_entry_array.sv
verilog/rob_retire.sv
verilog/rob_top.sv
tb/rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - verilog/isa_pkg.sv
  - verilog/rob_pkg.sv
  - verilog/rob_alloc_if.sv
  - verilog/rob_head_if.sv
  - verilog/rob_dispatch.sv
  - verilog/rob_entry_array.sv
  - verilog/rob_retire.sv
  - verilog/rob_top.sv
  - target: test
    files:
      - tb/rob_tb.sv
